//--- hw/cache_cfg_pkg.sv
// ==================================================
// Cache geometry constants and address field types
// Four sets of four ways, one 32-bit word per way
// ==================================================

package cache_cfg_pkg;

    // ==================================================
    // Geometry
    // ==================================================

    // Request address and data word widths
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;

    // Sets and associativity
    localparam int NUM_SETS = 4;
    localparam int NUM_WAYS = 4;

    // Address split: tag | index | offset
    localparam int OFFSET_W = 3;
    localparam int IDX_W    = $clog2(NUM_SETS);
    localparam int TAG_W    = ADDR_W - IDX_W - OFFSET_W;

    // Way index width
    localparam int WAY_W    = $clog2(NUM_WAYS);

    // One history bit per unordered way pair
    localparam int HIST_W   = NUM_WAYS * (NUM_WAYS - 1) / 2;

    // ==================================================
    // Field types
    // ==================================================

    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [IDX_W-1:0]    idx_t;
    typedef logic [WAY_W-1:0]    way_t;
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [ADDR_W-1:0]   addr_t;

    // One bit per way, used one-hot or as a flag vector
    typedef logic [NUM_WAYS-1:0] way_mask_t;

endpackage

//--- hw/cache_req_pkg.sv
// ==================================================
// Cache command encoding and transaction structs
// Request, response and stored entry layouts
// ==================================================

package cache_req_pkg;

    // ==================================================
    // Commands
    // ==================================================

    // Idle does nothing, fills place a block on a miss
    typedef enum logic [2:0] {
        CMD_IDLE       = 3'd0,
        CMD_LOAD       = 3'd1,
        CMD_STORE      = 3'd2,
        CMD_LOAD_FILL  = 3'd3,
        CMD_STORE_FILL = 3'd4
    } cmd_e;

    // ==================================================
    // Request and response
    // ==================================================

    // Command from the cache controller, sampled every cycle
    typedef struct packed {
        cmd_e                  cmd;
        cache_cfg_pkg::addr_t  addr;
        // Store data, also the fill block
        cache_cfg_pkg::data_t  wdata;
    } cache_req_t;

    // Same-cycle result of the command
    typedef struct packed {
        logic                  hit;
        // Hit way data, zero on a miss
        cache_cfg_pkg::data_t  rdata;
        // Victim block leaving the set
        logic                  evict;
        logic                  evict_dirty;
        cache_cfg_pkg::addr_t  evict_addr;
        cache_cfg_pkg::data_t  evict_data;
    } cache_rsp_t;

    // ==================================================
    // Stored entry
    // ==================================================

    // One way of one set
    typedef struct packed {
        logic                  valid;
        // Written since the fill, needs write-back
        logic                  dirty;
        cache_cfg_pkg::tag_t   tag;
        cache_cfg_pkg::data_t  data;
    } cache_entry_t;

endpackage

//--- hw/cache_way_lookup.sv
// ==================================================
// Way lookup for the selected set
// Parallel tag compare and lowest empty way search
// ==================================================

`timescale 1ns/1ps

module cache_way_lookup (
    // Ways of the selected set
    input  cache_req_pkg::cache_entry_t [cache_cfg_pkg::NUM_WAYS-1:0] set_entries_i,
    // Tag of the request
    input  cache_cfg_pkg::tag_t                                         tag_i,
    // Hit result, one-hot way
    output logic                                                        hit_o,
    output cache_cfg_pkg::way_mask_t                                    hit_way_o,
    // Lowest-index invalid way, one-hot
    output logic                                                        empty_valid_o,
    output cache_cfg_pkg::way_mask_t                                    empty_way_o
);

    // ==================================================
    // Tag compare
    // ==================================================

    // Every way compares at once, only valid ways can hit
    always_comb begin
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            hit_way_o[w] = set_entries_i[w].valid && (set_entries_i[w].tag == tag_i);
        end
    end

    assign hit_o = |hit_way_o;

    // ==================================================
    // Empty way search
    // ==================================================

    // Priority pick, lowest index wins
    always_comb begin
        logic found;
        found       = 1'b0;
        empty_way_o = '0;
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            if (!set_entries_i[w].valid && !found) begin
                empty_way_o[w] = 1'b1;
                found          = 1'b1;
            end
        end
        empty_valid_o = found;
    end

    // ==================================================
    // Checks
    // ==================================================

    // Fills never place a second copy of a tag in a set,
    // so at most one way may match
    always_comb begin
        assert final ($onehot0(hit_way_o))
        else $error("Tag matches more than one way of the set");
    end

endmodule

//--- hw/cache_lru_matrix.sv
// ==================================================
// LRU use-history matrix, one per set
// Pairwise recency bits and oldest way selection
// ==================================================

`timescale 1ns/1ps

module cache_lru_matrix (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // Set of the current request
    input  cache_cfg_pkg::idx_t       idx_i,
    // Access strobe and one-hot accessed way
    input  logic                      access_i,
    input  cache_cfg_pkg::way_mask_t  access_way_i,
    // Oldest way of the selected set
    output cache_cfg_pkg::way_mask_t  victim_way_o
);

    // Bit for pair lo < hi is set when lo was used after hi
    logic [cache_cfg_pkg::NUM_SETS-1:0][cache_cfg_pkg::HIST_W-1:0] hist_q;
    logic [cache_cfg_pkg::HIST_W-1:0]                              cur_hist;
    logic [cache_cfg_pkg::HIST_W-1:0]                              hist_next;

    // Position of pair (lo, hi) in the flattened upper triangle
    function automatic int unsigned pair_idx(input cache_cfg_pkg::way_t lo,
                                             input cache_cfg_pkg::way_t hi);
        return lo * (2 * cache_cfg_pkg::NUM_WAYS - lo - 1) / 2 + (hi - lo - 1);
    endfunction

    assign cur_hist = hist_q[idx_i];

    // ==================================================
    // Victim selection
    // ==================================================

    // A way is the victim when every other way was used after it
    always_comb begin
        logic oldest;
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            oldest = 1'b1;
            for (int o = 0; o < cache_cfg_pkg::NUM_WAYS; o++) begin
                if (o < w) begin
                    // Bit clear means w came after o
                    if (!cur_hist[pair_idx(cache_cfg_pkg::way_t'(o), cache_cfg_pkg::way_t'(w))])
                        oldest = 1'b0;
                end else if (o > w) begin
                    // Bit set means w came after o
                    if (cur_hist[pair_idx(cache_cfg_pkg::way_t'(w), cache_cfg_pkg::way_t'(o))])
                        oldest = 1'b0;
                end
            end
            victim_way_o[w] = oldest;
        end
    end

    // ==================================================
    // History update
    // ==================================================

    // Accessed way becomes newer than every other way
    always_comb begin
        hist_next = cur_hist;
        for (int a = 0; a < cache_cfg_pkg::NUM_WAYS; a++) begin
            if (access_way_i[a]) begin
                for (int o = 0; o < cache_cfg_pkg::NUM_WAYS; o++) begin
                    if (a < o)
                        hist_next[pair_idx(cache_cfg_pkg::way_t'(a), cache_cfg_pkg::way_t'(o))] = 1'b1;
                    else if (a > o)
                        hist_next[pair_idx(cache_cfg_pkg::way_t'(o), cache_cfg_pkg::way_t'(a))] = 1'b0;
                end
            end
        end
    end

    // All zero after reset leaves way 0 oldest and way 3 newest
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            hist_q <= '0;
        end else if (access_i) begin
            hist_q[idx_i] <= hist_next;
        end
    end

    // The matrix must always encode a strict age order
    victim_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot(victim_way_o));

endmodule

//--- hw/cache_store.sv
// ==================================================
// Cache entry array and command handling
// Way choice, entry write-back and response build
// ==================================================

`timescale 1ns/1ps

module cache_store (
    input  logic                                                        clk_i,
    input  logic                                                        rst_i,
    input  cache_req_pkg::cache_req_t                                   req_i,
    // Address fields of the request
    input  cache_cfg_pkg::tag_t                                         tag_i,
    input  cache_cfg_pkg::idx_t                                         idx_i,
    // Ways of the selected set, to the lookup
    output cache_req_pkg::cache_entry_t [cache_cfg_pkg::NUM_WAYS-1:0] set_entries_o,
    // Lookup results
    input  logic                                                        hit_i,
    input  cache_cfg_pkg::way_mask_t                                    hit_way_i,
    input  logic                                                        empty_valid_i,
    input  cache_cfg_pkg::way_mask_t                                    empty_way_i,
    // Oldest way from the LRU matrix
    input  cache_cfg_pkg::way_mask_t                                    victim_way_i,
    // Way touched by this command
    output logic                                                        access_o,
    output cache_cfg_pkg::way_mask_t                                    access_way_o,
    output cache_req_pkg::cache_rsp_t                                   rsp_o
);

    // Entry array and next value of the selected set
    cache_req_pkg::cache_entry_t [cache_cfg_pkg::NUM_SETS-1:0][cache_cfg_pkg::NUM_WAYS-1:0]
        entries_q;
    cache_req_pkg::cache_entry_t [cache_cfg_pkg::NUM_WAYS-1:0] set_next;

    cache_req_pkg::cmd_e          cmd;
    cache_req_pkg::cache_entry_t  hit_entry;
    cache_req_pkg::cache_entry_t  victim_entry;
    cache_cfg_pkg::way_mask_t     fill_way;
    logic                         is_write;
    logic                         is_fill;

    assign set_entries_o = entries_q[idx_i];
    assign cmd           = req_i.cmd;

    // ==================================================
    // Command decode
    // ==================================================

    always_comb begin
        is_write = 1'b0;
        is_fill  = 1'b0;
        unique case (cmd)
            cache_req_pkg::CMD_STORE:      is_write = 1'b1;
            cache_req_pkg::CMD_LOAD_FILL:  is_fill  = 1'b1;
            cache_req_pkg::CMD_STORE_FILL: begin
                is_write = 1'b1;
                is_fill  = 1'b1;
            end
            default: ;
        endcase
    end

    // Entries behind the one-hot hit and victim ways
    always_comb begin
        hit_entry    = '0;
        victim_entry = '0;
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            if (hit_way_i[w])    hit_entry    = set_entries_o[w];
            if (victim_way_i[w]) victim_entry = set_entries_o[w];
        end
    end

    // Miss fill goes to the lowest empty way, else the LRU way
    assign fill_way = empty_valid_i ? empty_way_i : victim_way_i;

    // ==================================================
    // Response and next set
    // ==================================================

    always_comb begin
        set_next     = set_entries_o;
        rsp_o        = '0;
        access_o     = 1'b0;
        access_way_o = '0;
        if (cmd != cache_req_pkg::CMD_IDLE && hit_i) begin
            // A hit reads out the way and stores also overwrite it and mark it dirty
            rsp_o.hit    = 1'b1;
            rsp_o.rdata  = hit_entry.data;
            access_o     = 1'b1;
            access_way_o = hit_way_i;
            for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
                if (hit_way_i[w] && is_write) begin
                    set_next[w].data  = req_i.wdata;
                    set_next[w].dirty = 1'b1;
                end
            end
        end else if (is_fill) begin
            // A full set reports the block being replaced
            if (!empty_valid_i) begin
                rsp_o.evict       = 1'b1;
                rsp_o.evict_dirty = victim_entry.dirty;
                rsp_o.evict_data  = victim_entry.data;
                rsp_o.evict_addr  = {victim_entry.tag, idx_i,
                                     {cache_cfg_pkg::OFFSET_W{1'b0}}};
            end
            access_o     = 1'b1;
            access_way_o = fill_way;
            // Store fill lands dirty, load fill lands clean
            for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
                if (fill_way[w]) begin
                    set_next[w].valid = 1'b1;
                    set_next[w].dirty = is_write;
                    set_next[w].tag   = tag_i;
                    set_next[w].data  = req_i.wdata;
                end
            end
        end
    end

    // Only the selected set changes, others hold
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int s = 0; s < cache_cfg_pkg::NUM_SETS; s++) begin
                for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
                    entries_q[s][w].valid <= 1'b0;
                    entries_q[s][w].dirty <= 1'b0;
                end
            end
        end else begin
            entries_q[idx_i] <= set_next;
        end
    end

    // Hit way from the lookup and victim from the LRU matrix
    // must each name exactly one way
    access_onehot_a: assert property (@(posedge clk_i) disable iff (rst_i)
        access_o |-> $onehot(access_way_o));

endmodule

//--- hw/cache_mem.sv
// ==================================================
// Cache memory array top level
// Address split and wiring of store, lookup and LRU
// ==================================================

`timescale 1ns/1ps

module cache_mem (
    input  logic                       clk_i,
    input  logic                       rst_i,
    // One command per cycle, result in the same cycle
    input  cache_req_pkg::cache_req_t  req_i,
    output cache_req_pkg::cache_rsp_t  rsp_o
);

    // Address fields
    cache_cfg_pkg::tag_t       req_tag;
    cache_cfg_pkg::idx_t       req_idx;

    // Selected set and lookup results
    cache_req_pkg::cache_entry_t [cache_cfg_pkg::NUM_WAYS-1:0] set_entries;
    logic                      hit;
    cache_cfg_pkg::way_mask_t  hit_way;
    logic                      empty_valid;
    cache_cfg_pkg::way_mask_t  empty_way;

    // Replacement state
    cache_cfg_pkg::way_mask_t  victim_way;
    logic                      access;
    cache_cfg_pkg::way_mask_t  access_way;

    // ==================================================
    // Address split
    // ==================================================

    // Offset bits are ignored, a block is one word
    assign req_tag = req_i.addr[cache_cfg_pkg::ADDR_W-1 -: cache_cfg_pkg::TAG_W];
    assign req_idx = req_i.addr[cache_cfg_pkg::OFFSET_W +: cache_cfg_pkg::IDX_W];

    // ==================================================
    // Blocks
    // ==================================================

    cache_store u_store (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req_i),
        .tag_i         (req_tag),
        .idx_i         (req_idx),
        .set_entries_o (set_entries),
        .hit_i         (hit),
        .hit_way_i     (hit_way),
        .empty_valid_i (empty_valid),
        .empty_way_i   (empty_way),
        .victim_way_i  (victim_way),
        .access_o      (access),
        .access_way_o  (access_way),
        .rsp_o         (rsp_o)
    );

    cache_way_lookup u_lookup (
        .set_entries_i (set_entries),
        .tag_i         (req_tag),
        .hit_o         (hit),
        .hit_way_o     (hit_way),
        .empty_valid_o (empty_valid),
        .empty_way_o   (empty_way)
    );

    cache_lru_matrix u_lru (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .idx_i         (req_idx),
        .access_i      (access),
        .access_way_i  (access_way),
        .victim_way_o  (victim_way)
    );

endmodule

//--- tb/cache_model.svh
// ==================================================
// Reference model of the cache array
// Tags, data, dirty bits and per-way use stamps
// ==================================================

`ifndef CACHE_MODEL_SVH
`define CACHE_MODEL_SVH

// Model state, indexed [set][way]
logic                 m_valid [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
logic                 m_dirty [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
cache_cfg_pkg::tag_t  m_tag   [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
cache_cfg_pkg::data_t m_data  [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
// Larger stamp means more recently used
int unsigned          m_stamp [cache_cfg_pkg::NUM_SETS][cache_cfg_pkg::NUM_WAYS];
int unsigned          m_clock;

// Empty cache, age order 0, 1, 2, 3 with way 0 oldest
function automatic void reset_model();
    for (int s = 0; s < cache_cfg_pkg::NUM_SETS; s++) begin
        for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
            m_valid[s][w] = 1'b0;
            m_dirty[s][w] = 1'b0;
            m_stamp[s][w] = w;
        end
    end
    m_clock = cache_cfg_pkg::NUM_WAYS;
endfunction

// Way holding the tag, -1 on a miss
function automatic int find_hit_way(input cache_cfg_pkg::idx_t idx,
                                    input cache_cfg_pkg::tag_t tag);
    for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
        if (m_valid[idx][w] && m_tag[idx][w] == tag)
            return w;
    end
    return -1;
endfunction

// Lowest invalid way, -1 when the set is full
function automatic int find_empty_way(input cache_cfg_pkg::idx_t idx);
    for (int w = 0; w < cache_cfg_pkg::NUM_WAYS; w++) begin
        if (!m_valid[idx][w])
            return w;
    end
    return -1;
endfunction

// Way with the smallest use stamp
function automatic int find_oldest_way(input cache_cfg_pkg::idx_t idx);
    int best;
    best = 0;
    for (int w = 1; w < cache_cfg_pkg::NUM_WAYS; w++) begin
        if (m_stamp[idx][w] < m_stamp[idx][best])
            best = w;
    end
    return best;
endfunction

function automatic void mark_used(input cache_cfg_pkg::idx_t idx, input int way);
    m_clock          = m_clock + 1;
    m_stamp[idx][way] = m_clock;
endfunction

// Expected same-cycle response
function automatic cache_req_pkg::cache_rsp_t predict_response(
    input cache_req_pkg::cmd_e cmd,
    input cache_cfg_pkg::tag_t tag,
    input cache_cfg_pkg::idx_t idx
);
    cache_req_pkg::cache_rsp_t rsp;
    int                        hw;
    int                        vw;
    rsp = '0;
    if (cmd == cache_req_pkg::CMD_IDLE)
        return rsp;
    hw = find_hit_way(idx, tag);
    if (hw >= 0) begin
        rsp.hit   = 1'b1;
        rsp.rdata = m_data[idx][hw];
    end else if (cmd == cache_req_pkg::CMD_LOAD_FILL || cmd == cache_req_pkg::CMD_STORE_FILL) begin
        // Full set gives up its oldest way
        if (find_empty_way(idx) < 0) begin
            vw                = find_oldest_way(idx);
            rsp.evict         = 1'b1;
            rsp.evict_dirty   = m_dirty[idx][vw];
            rsp.evict_data    = m_data[idx][vw];
            rsp.evict_addr    = {m_tag[idx][vw], idx, {cache_cfg_pkg::OFFSET_W{1'b0}}};
        end
    end
    return rsp;
endfunction

// State change taken at the clock edge
function automatic void apply_to_model(
    input cache_req_pkg::cmd_e  cmd,
    input cache_cfg_pkg::tag_t  tag,
    input cache_cfg_pkg::idx_t  idx,
    input cache_cfg_pkg::data_t wdata
);
    int   w;
    logic is_write;
    logic is_fill;
    is_write = (cmd == cache_req_pkg::CMD_STORE || cmd == cache_req_pkg::CMD_STORE_FILL);
    is_fill  = (cmd == cache_req_pkg::CMD_LOAD_FILL || cmd == cache_req_pkg::CMD_STORE_FILL);
    if (cmd == cache_req_pkg::CMD_IDLE)
        return;
    w = find_hit_way(idx, tag);
    if (w >= 0) begin
        if (is_write) begin
            m_data[idx][w]  = wdata;
            m_dirty[idx][w] = 1'b1;
        end
        mark_used(idx, w);
    end else if (is_fill) begin
        w = find_empty_way(idx);
        if (w < 0)
            w = find_oldest_way(idx);
        m_valid[idx][w] = 1'b1;
        // Store fill lands dirty, load fill clean
        m_dirty[idx][w] = is_write;
        m_tag[idx][w]   = tag;
        m_data[idx][w]  = wdata;
        mark_used(idx, w);
    end
endfunction

`endif

//--- tb/cache_mem_tb.sv
// ==================================================
// Testbench for the cache memory array
// LFSR stimulus checked against a reference model
// ==================================================

`timescale 1ns/1ps

module cache_mem_tb;

    localparam int          NUM_REQS     = 2000;
    localparam int          RESET_CYCLES = 2;
    // Request count plus a 5 percent margin for reset and directed loads
    localparam int          MAX_CYCLES   = NUM_REQS + NUM_REQS / 20;
    localparam logic [31:0] LFSR_SEED    = 32'h6018055b;
    localparam logic [31:0] LFSR_TAPS    = 32'h80200003;

    logic                      clk_i;
    logic                      rst_i;
    cache_req_pkg::cache_req_t req_i;
    cache_req_pkg::cache_rsp_t rsp_o;

    logic [31:0]               lfsr_q;
    int unsigned               cycle_cnt = 0;
    int unsigned               err_cnt   = 0;

    `include "cache_model.svh"

    cache_mem UUT (
        .clk_i (clk_i),
        .rst_i (rst_i),
        .req_i (req_i),
        .rsp_o (rsp_o)
    );

    // ==================================================
    // Clock and timeout
    // ==================================================

    initial clk_i = 1'b0;
    always #4 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Testbench failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // ==================================================
    // Stimulus helpers
    // ==================================================

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int unsigned n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_q[0])
                lfsr_q = (lfsr_q >> 1) ^ LFSR_TAPS;
            else
                lfsr_q = lfsr_q >> 1;
            val = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    // Small tag pool so sets fill and evict often
    function automatic cache_cfg_pkg::tag_t test_tag(input logic [2:0] sel);
        case (sel)
            3'd0:    return 27'h0000001;
            3'd1:    return 27'h0000002;
            3'd2:    return 27'h5A5A5A5;
            3'd3:    return 27'h7FFFFFF;
            3'd4:    return 27'h1234567;
            3'd5:    return 27'h0ABCDEF;
            3'd6:    return 27'h4000000;
            default: return 27'h3C3C3C3;
        endcase
    endfunction

    // Fills weighted up to reach full sets sooner
    function automatic cache_req_pkg::cmd_e pick_cmd(input logic [2:0] sel);
        case (sel)
            3'd0:       return cache_req_pkg::CMD_IDLE;
            3'd1, 3'd7: return cache_req_pkg::CMD_LOAD;
            3'd2:       return cache_req_pkg::CMD_STORE;
            3'd3, 3'd5: return cache_req_pkg::CMD_LOAD_FILL;
            default:    return cache_req_pkg::CMD_STORE_FILL;
        endcase
    endfunction

    // ==================================================
    // Checking
    // ==================================================

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Testbench failed");
            $fatal(1, "Response mismatch");
        end
    endtask

    task automatic check_response(input cache_req_pkg::cache_rsp_t exp);
        check_field("hit", 64'(rsp_o.hit), 64'(exp.hit));
        check_field("rdata", 64'(rsp_o.rdata), 64'(exp.rdata));
        check_field("evict", 64'(rsp_o.evict), 64'(exp.evict));
        check_field("evict_dirty", 64'(rsp_o.evict_dirty), 64'(exp.evict_dirty));
        check_field("evict_addr", 64'(rsp_o.evict_addr), 64'(exp.evict_addr));
        check_field("evict_data", 64'(rsp_o.evict_data), 64'(exp.evict_data));
    endtask

    // Drive at the rising edge, check mid-cycle, model follows the edge
    task automatic issue_request(input cache_req_pkg::cmd_e  cmd,
                                 input cache_cfg_pkg::tag_t  tag,
                                 input cache_cfg_pkg::idx_t  idx,
                                 input cache_cfg_pkg::data_t wdata);
        cache_req_pkg::cache_req_t req;
        req.cmd   = cmd;
        req.addr  = {tag, idx, {cache_cfg_pkg::OFFSET_W{1'b0}}};
        req.wdata = wdata;
        req_i <= req;
        @(negedge clk_i);
        check_response(predict_response(cmd, tag, idx));
        apply_to_model(cmd, tag, idx, wdata);
        @(posedge clk_i);
    endtask

    // ==================================================
    // Main sequence
    // ==================================================

    initial begin
        cache_req_pkg::cmd_e  cmd;
        cache_cfg_pkg::tag_t  tag;
        cache_cfg_pkg::idx_t  idx;
        cache_cfg_pkg::data_t wdata;
        rst_i  = 1'b1;
        req_i  = '0;
        lfsr_q = LFSR_SEED;
        reset_model();
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_i <= 1'b0;

        // Every load misses in the empty cache
        for (int s = 0; s < cache_cfg_pkg::NUM_SETS; s++) begin
            tag = test_tag(3'(rand_bits(3)));
            issue_request(cache_req_pkg::CMD_LOAD, tag, cache_cfg_pkg::idx_t'(s), '0);
        end

        // Random mix of hits, fills and evictions
        for (int n = 0; n < NUM_REQS; n++) begin
            cmd   = pick_cmd(3'(rand_bits(3)));
            idx   = cache_cfg_pkg::idx_t'(rand_bits(cache_cfg_pkg::IDX_W));
            tag   = test_tag(3'(rand_bits(3)));
            wdata = rand_bits(32);
            issue_request(cmd, tag, idx, wdata);
        end

        if (err_cnt == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Testbench failed");
            $fatal(1, "Checks reported errors");
        end
    end

endmodule

//--- project.f
+incdir+tb
hw/cache_cfg_pkg.sv
hw/cache_req_pkg.sv
hw/cache_way_lookup.sv
hw/cache_lru_matrix.sv
hw/cache_store.sv
hw/cache_mem.sv
tb/cache_mem_tb.sv

//--- Makefile
# Verilator build and run for the cache memory testbench
# Any variable can be overridden, e.g. make TOP=cache_mem lint

VERILATOR  ?= verilator
TOP        ?= cache_mem_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --timing -Wall
PASS_MSG   ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# Fails unless the pass line appears in the simulation output
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
